/* source/xm_regs_pkg.sv */
// Host register map of the text-mode front end.
// Register numbers 9 to 15 are unused: they read zero and ignore writes.
// The banner is 8 ASCII characters, followed on screen by the version
// as digit '.' digit digit.
package xm_regs_pkg;

    localparam int XM_BYTE_W = 8;           // host data bus width
    localparam int XM_REG_W  = 4;           // register number width

    localparam logic [XM_REG_W-1:0] XM_XR_ADDR  = 4'h0;    // XR address, odd byte reads XR
    localparam logic [XM_REG_W-1:0] XM_XR_DATA  = 4'h1;    // XR data, odd byte writes XR
    localparam logic [XM_REG_W-1:0] XM_RD_INCR  = 4'h2;
    localparam logic [XM_REG_W-1:0] XM_RD_ADDR  = 4'h3;    // odd byte starts a VRAM read
    localparam logic [XM_REG_W-1:0] XM_WR_INCR  = 4'h4;
    localparam logic [XM_REG_W-1:0] XM_WR_ADDR  = 4'h5;
    localparam logic [XM_REG_W-1:0] XM_DATA     = 4'h6;    // VRAM data port
    localparam logic [XM_REG_W-1:0] XM_DATA_2   = 4'h7;    // same port, second number
    localparam logic [XM_REG_W-1:0] XM_SYS_CTRL = 4'h8;

    localparam logic [11:0] VERSION    = 12'h031;   // three hex digits
    localparam logic [63:0] BANNER     = "TXTVID v";
    localparam int          BANNER_LEN = 12;        // name, digit, '.', digit, digit

endpackage

/* source/vram_pkg.sv */
// Shared video-memory bus definitions.
// A text cell is one 16-bit word: attribute in the high byte, glyph low.
// Only the first CLEAR_WORDS cells are cleared after reset.
package vram_pkg;

    localparam int MEM_ADDR_W = 16;
    localparam int MEM_DATA_W = 16;

    // one VRAM word, seen raw or as a text cell
    typedef union packed {
        logic [MEM_DATA_W-1:0] word;
        struct packed {
            logic [7:0] attr;
            logic [7:0] glyph;
        } ch;
    } cell_t;

    localparam cell_t CLEAR_CELL = 16'h0220;   // blank, attribute 02
    localparam int    CLEAR_WORDS = 64;
    localparam int    TILES_WIDE  = 80;         // cells per text row

    localparam logic [7:0] BANNER_ATTR = 8'h02;

endpackage

/* source/blit_regs.sv */
// Host register unit.
// Host strobes are single-cycle and synchronous to clk.
// Only odd-byte writes (and odd-byte DATA reads) start a memory access;
// even bytes are latched until the matching odd byte arrives.
// One request is held at a time: a newer command replaces a pending one.
`timescale 1ns/1ps

module blit_regs (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic                               bus_wr_strobe_i,
    input  logic                               bus_rd_strobe_i,
    input  logic [xm_regs_pkg::XM_REG_W-1:0]   bus_reg_num_i,
    input  logic                               bus_bytesel_i,     // 0 = even (high) byte
    input  logic [xm_regs_pkg::XM_BYTE_W-1:0]  bus_data_i,
    output logic [xm_regs_pkg::XM_BYTE_W-1:0]  bus_data_o,
    input  logic                               host_gnt_i,
    input  logic                               host_rd_ack_i,
    input  logic [vram_pkg::MEM_DATA_W-1:0]    vram_data_i,
    input  logic [vram_pkg::MEM_DATA_W-1:0]    xr_data_i,
    input  logic                               boot_busy_i,
    output logic                               host_req_o,
    output logic                               host_xr_o,
    output logic                               host_wr_o,
    output logic [vram_pkg::MEM_ADDR_W-1:0]    host_addr_o,
    output logic [vram_pkg::MEM_DATA_W-1:0]    host_wdata_o,
    output logic                               reconfig_o,
    output logic [1:0]                         boot_select_o,
    output logic [3:0]                         intr_mask_o
);
    import xm_regs_pkg::*;
    import vram_pkg::*;

    logic [MEM_ADDR_W-1:0] xr_addr;
    logic [MEM_ADDR_W-1:0] rd_incr;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic [MEM_ADDR_W-1:0] wr_incr;
    logic [MEM_ADDR_W-1:0] wr_addr;
    logic [MEM_DATA_W-1:0] xr_rd_data;      // last XR read word
    logic [MEM_DATA_W-1:0] vram_rd_data;    // last VRAM read word
    logic                  rd_is_xr;        // kind of the read in flight

    logic [XM_BYTE_W-1:0]  xr_data_even;
    logic [XM_BYTE_W-1:0]  data_even;
    logic [XM_BYTE_W-1:0]  other_even;      // generic even latch
    logic [XM_REG_W-1:0]   other_reg;       // register that filled it
    logic [XM_BYTE_W-1:0]  even_byte;

    logic                  cmd_valid;
    logic                  cmd_xr;
    logic                  cmd_wr;
    logic [MEM_ADDR_W-1:0] cmd_addr;
    logic [MEM_DATA_W-1:0] cmd_wdata;
    logic [MEM_DATA_W-1:0] rd_word;

    assign even_byte = (other_reg == bus_reg_num_i) ? other_even : '0;

    // readback, word picked by register then byte by select
    always_comb begin
        case (bus_reg_num_i)
            XM_XR_ADDR:          rd_word = xr_addr;
            XM_XR_DATA:          rd_word = xr_rd_data;
            XM_RD_INCR:          rd_word = rd_incr;
            XM_RD_ADDR:          rd_word = rd_addr;
            XM_WR_INCR:          rd_word = wr_incr;
            XM_WR_ADDR:          rd_word = wr_addr;
            XM_DATA, XM_DATA_2:  rd_word = vram_rd_data;
            XM_SYS_CTRL:         rd_word = {boot_busy_i, 3'b000, intr_mask_o, 8'h00};
            default:             rd_word = '0;
        endcase
        bus_data_o = bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
    end

    // which host byte access turns into a memory request
    always_comb begin
        cmd_valid = 1'b0;
        cmd_xr    = 1'b0;
        cmd_wr    = 1'b0;
        cmd_addr  = wr_addr;
        cmd_wdata = {data_even, bus_data_i};
        if (bus_wr_strobe_i && bus_bytesel_i) begin
            case (bus_reg_num_i)
                XM_XR_ADDR: begin
                    cmd_valid = 1'b1;
                    cmd_xr    = 1'b1;
                    cmd_addr  = {xr_addr[15:8], bus_data_i};    // read the new address
                end
                XM_XR_DATA: begin
                    cmd_valid = 1'b1;
                    cmd_xr    = 1'b1;
                    cmd_wr    = 1'b1;
                    cmd_addr  = xr_addr;
                    cmd_wdata = {xr_data_even, bus_data_i};
                end
                XM_RD_ADDR: begin
                    cmd_valid = 1'b1;
                    cmd_addr  = {rd_addr[15:8], bus_data_i};
                end
                XM_DATA, XM_DATA_2: begin
                    cmd_valid = 1'b1;
                    cmd_wr    = 1'b1;
                end
                default: ;
            endcase
        end
        if (bus_rd_strobe_i && bus_bytesel_i &&
            (bus_reg_num_i == XM_DATA || bus_reg_num_i == XM_DATA_2)) begin
            cmd_valid = 1'b1;       // prefetch next read word
            cmd_addr  = rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            host_req_o    <= 1'b0;
            reconfig_o    <= 1'b0;
            boot_select_o <= 2'b00;
            intr_mask_o   <= 4'b1000;
            xr_addr       <= '0;
            rd_incr       <= '0;
            rd_addr       <= '0;
            wr_incr       <= '0;
            wr_addr       <= '0;
            other_reg     <= '0;
        end else begin
            // the address used by a granted request steps on
            if (host_gnt_i) begin
                host_req_o <= 1'b0;
                rd_is_xr   <= host_xr_o;
                if (host_xr_o && host_wr_o) begin
                    xr_addr <= xr_addr + 1'b1;
                end else if (!host_xr_o && host_wr_o) begin
                    wr_addr <= wr_addr + wr_incr;
                end else if (!host_xr_o) begin
                    rd_addr <= rd_addr + rd_incr;
                end
            end

            if (host_rd_ack_i) begin
                if (rd_is_xr) begin
                    xr_rd_data <= xr_data_i;
                end else begin
                    vram_rd_data <= vram_data_i;
                end
            end

            if (cmd_valid) begin
                host_req_o   <= 1'b1;       // replaces anything pending
                host_xr_o    <= cmd_xr;
                host_wr_o    <= cmd_wr;
                host_addr_o  <= cmd_addr;
                host_wdata_o <= cmd_wdata;
            end

            if (bus_wr_strobe_i && !bus_bytesel_i) begin
                case (bus_reg_num_i)
                    XM_XR_ADDR:         xr_addr[15:8] <= bus_data_i;
                    XM_RD_ADDR:         rd_addr[15:8] <= bus_data_i;
                    XM_WR_ADDR:         wr_addr[15:8] <= bus_data_i;
                    XM_XR_DATA:         xr_data_even  <= bus_data_i;
                    XM_DATA, XM_DATA_2: data_even     <= bus_data_i;
                    default: begin
                        other_even <= bus_data_i;
                        other_reg  <= bus_reg_num_i;
                    end
                endcase
            end else if (bus_wr_strobe_i) begin
                case (bus_reg_num_i)
                    XM_XR_ADDR: xr_addr[7:0] <= bus_data_i;
                    XM_RD_ADDR: rd_addr[7:0] <= bus_data_i;
                    XM_WR_ADDR: wr_addr[7:0] <= bus_data_i;
                    XM_RD_INCR: rd_incr      <= {even_byte, bus_data_i};
                    XM_WR_INCR: wr_incr      <= {even_byte, bus_data_i};
                    XM_SYS_CTRL: begin
                        reconfig_o    <= even_byte[6];
                        boot_select_o <= even_byte[5:4];
                        intr_mask_o   <= even_byte[3:0];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* source/boot_writer.sv */
// Post-reset VRAM clear and banner writer.
// Clears cells 0 to CLEAR_WORDS-1, then writes the banner on the second
// text row starting at column 1. One write is offered per grant.
// Version digits are shown as lower-case hex.
`timescale 1ns/1ps

module boot_writer (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             boot_gnt_i,
    output logic                             boot_req_o,
    output logic [vram_pkg::MEM_ADDR_W-1:0]  boot_addr_o,
    output vram_pkg::cell_t                  boot_wdata_o,
    output logic                             boot_busy_o
);
    import xm_regs_pkg::*;
    import vram_pkg::*;

    logic                           banner_phase;   // 0 while clearing
    logic [$clog2(CLEAR_WORDS)-1:0] cnt;            // cell counter within phase
    logic [7:0]                     glyph;

    function automatic logic [7:0] hex_digit(input logic [3:0] n);
        hex_digit = (n > 4'd9) ? 8'h57 + {4'h0, n} : 8'h30 + {4'h0, n};
    endfunction

    always_comb begin
        case (cnt)
            8:       glyph = hex_digit(VERSION[11:8]);
            9:       glyph = 8'h2e;                   // '.'
            10:      glyph = hex_digit(VERSION[7:4]);
            11:      glyph = hex_digit(VERSION[3:0]);
            default: glyph = BANNER[63 - 8*cnt[2:0] -: 8];
        endcase

        if (banner_phase) begin
            boot_addr_o          = MEM_ADDR_W'(TILES_WIDE + 1 + cnt);
            boot_wdata_o.ch.attr  = BANNER_ATTR;
            boot_wdata_o.ch.glyph = glyph;
        end else begin
            boot_addr_o  = MEM_ADDR_W'(cnt);
            boot_wdata_o = CLEAR_CELL;
        end
    end

    assign boot_req_o = boot_busy_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            banner_phase <= 1'b0;
            boot_busy_o  <= 1'b1;
            cnt          <= '0;
        end else if (boot_gnt_i) begin
            cnt <= cnt + 1'b1;
            if (!banner_phase && cnt == CLEAR_WORDS - 1) begin
                banner_phase <= 1'b1;       // clear done, start banner
                cnt          <= '0;
            end else if (banner_phase && cnt == BANNER_LEN - 1) begin
                boot_busy_o  <= 1'b0;       // last banner cell granted
            end
        end
    end

endmodule

/* source/mem_arbiter.sv */
// Shared VRAM/XR bus arbiter.
// Nothing is granted while the video generator owns memory (vgen_sel_i high).
// The boot writer wins over the host. Grants are combinational pulses;
// the granted access is registered and appears on the bus the next cycle.
// Host read data arrives one cycle after the access, flagged by host_rd_ack_o.
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             vgen_sel_i,
    input  logic                             boot_req_i,
    input  logic [vram_pkg::MEM_ADDR_W-1:0]  boot_addr_i,
    input  vram_pkg::cell_t                  boot_wdata_i,
    input  logic                             host_req_i,
    input  logic                             host_xr_i,
    input  logic                             host_wr_i,
    input  logic [vram_pkg::MEM_ADDR_W-1:0]  host_addr_i,
    input  logic [vram_pkg::MEM_DATA_W-1:0]  host_wdata_i,
    output logic                             boot_gnt_o,
    output logic                             host_gnt_o,
    output logic                             host_rd_ack_o,
    output logic                             vram_sel_o,
    output logic                             xr_sel_o,
    output logic                             mem_wr_o,
    output logic [vram_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
    output logic [vram_pkg::MEM_DATA_W-1:0]  mem_data_o
);

    logic host_rd_pend;     // host read on the bus this cycle

    assign boot_gnt_o = !vgen_sel_i && boot_req_i;
    assign host_gnt_o = !vgen_sel_i && !boot_req_i && host_req_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o    <= 1'b0;
            xr_sel_o      <= 1'b0;
            mem_wr_o      <= 1'b0;
            host_rd_pend  <= 1'b0;
            host_rd_ack_o <= 1'b0;
        end else begin
            vram_sel_o    <= boot_gnt_o || (host_gnt_o && !host_xr_i);
            xr_sel_o      <= host_gnt_o && host_xr_i;
            mem_wr_o      <= boot_gnt_o || (host_gnt_o && host_wr_i);
            host_rd_pend  <= host_gnt_o && !host_wr_i;
            host_rd_ack_o <= host_rd_pend;      // data valid the cycle after access
        end
    end

    // bus payload
    always_ff @(posedge clk) begin
        if (boot_gnt_o) begin
            mem_addr_o <= boot_addr_i;
            mem_data_o <= boot_wdata_i.word;
        end else if (host_gnt_o) begin
            mem_addr_o <= host_addr_i;
            mem_data_o <= host_wdata_i;
        end
    end

endmodule

/* source/blitter_top.sv */
// Register front end of the text-mode video controller.
// Host strobes must be single-cycle pulses synchronous to clk.
// bus_data_o is combinational from bus_reg_num_i and bus_bytesel_i.
`timescale 1ns/1ps

module blitter_top (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic                               bus_wr_strobe_i,
    input  logic                               bus_rd_strobe_i,
    input  logic [xm_regs_pkg::XM_REG_W-1:0]   bus_reg_num_i,
    input  logic                               bus_bytesel_i,     // 0 = even (high) byte
    input  logic [xm_regs_pkg::XM_BYTE_W-1:0]  bus_data_i,
    output logic [xm_regs_pkg::XM_BYTE_W-1:0]  bus_data_o,
    input  logic                               vgen_sel_i,        // video owns memory
    output logic                               vram_sel_o,
    output logic                               xr_sel_o,
    output logic                               mem_wr_o,
    output logic [vram_pkg::MEM_ADDR_W-1:0]    mem_addr_o,
    output logic [vram_pkg::MEM_DATA_W-1:0]    mem_data_o,
    input  logic [vram_pkg::MEM_DATA_W-1:0]    vram_data_i,
    input  logic [vram_pkg::MEM_DATA_W-1:0]    xr_data_i,
    output logic                               reconfig_o,
    output logic [1:0]                         boot_select_o,
    output logic [3:0]                         intr_mask_o
);
    import vram_pkg::*;

    logic                  host_req;
    logic                  host_xr;
    logic                  host_wr;
    logic [MEM_ADDR_W-1:0] host_addr;
    logic [MEM_DATA_W-1:0] host_wdata;
    logic                  host_gnt;
    logic                  host_rd_ack;
    logic                  boot_req;
    logic [MEM_ADDR_W-1:0] boot_addr;
    cell_t                 boot_wdata;
    logic                  boot_gnt;
    logic                  boot_busy;

    blit_regs i_blit_regs (
        .clk             (clk),
        .reset_i         (reset_i),
        .bus_wr_strobe_i (bus_wr_strobe_i),
        .bus_rd_strobe_i (bus_rd_strobe_i),
        .bus_reg_num_i   (bus_reg_num_i),
        .bus_bytesel_i   (bus_bytesel_i),
        .bus_data_i      (bus_data_i),
        .bus_data_o      (bus_data_o),
        .host_gnt_i      (host_gnt),
        .host_rd_ack_i   (host_rd_ack),
        .vram_data_i     (vram_data_i),
        .xr_data_i       (xr_data_i),
        .boot_busy_i     (boot_busy),
        .host_req_o      (host_req),
        .host_xr_o       (host_xr),
        .host_wr_o       (host_wr),
        .host_addr_o     (host_addr),
        .host_wdata_o    (host_wdata),
        .reconfig_o      (reconfig_o),
        .boot_select_o   (boot_select_o),
        .intr_mask_o     (intr_mask_o)
    );

    boot_writer i_boot_writer (
        .clk          (clk),
        .reset_i      (reset_i),
        .boot_gnt_i   (boot_gnt),
        .boot_req_o   (boot_req),
        .boot_addr_o  (boot_addr),
        .boot_wdata_o (boot_wdata),
        .boot_busy_o  (boot_busy)
    );

    mem_arbiter i_mem_arbiter (
        .clk           (clk),
        .reset_i       (reset_i),
        .vgen_sel_i    (vgen_sel_i),
        .boot_req_i    (boot_req),
        .boot_addr_i   (boot_addr),
        .boot_wdata_i  (boot_wdata),
        .host_req_i    (host_req),
        .host_xr_i     (host_xr),
        .host_wr_i     (host_wr),
        .host_addr_i   (host_addr),
        .host_wdata_i  (host_wdata),
        .boot_gnt_o    (boot_gnt),
        .host_gnt_o    (host_gnt),
        .host_rd_ack_o (host_rd_ack),
        .vram_sel_o    (vram_sel_o),
        .xr_sel_o      (xr_sel_o),
        .mem_wr_o      (mem_wr_o),
        .mem_addr_o    (mem_addr_o),
        .mem_data_o    (mem_data_o)
    );

endmodule

/* tests/blitter_chk.sv */
// Memory bus checks, bound into blitter_top.
// Assumes the selects and mem_wr_o are registered outputs of the arbiter.
`timescale 1ns/1ps

module blitter_chk (
    input logic clk,
    input logic reset_i,
    input logic vgen_sel_i,
    input logic vram_sel_i,
    input logic xr_sel_i,
    input logic mem_wr_i
);

    a_one_select: assert property (@(posedge clk) disable iff (reset_i)
        !(vram_sel_i && xr_sel_i)) else $error("VRAM and XR selects high together");

    a_wr_needs_select: assert property (@(posedge clk) disable iff (reset_i)
        mem_wr_i |-> (vram_sel_i || xr_sel_i)) else $error("write flag without a select");

    // grant only in a cycle the video generator left free
    a_video_free: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_i || xr_sel_i) |-> $past(!vgen_sel_i)) else $error("access after video cycle");

    a_quiet_after_reset: assert property (@(posedge clk)
        $past(reset_i) |-> !(vram_sel_i || xr_sel_i)) else $error("select high after reset");

endmodule

bind blitter_top blitter_chk i_blitter_chk (
    .clk        (clk),
    .reset_i    (reset_i),
    .vgen_sel_i (vgen_sel_i),
    .vram_sel_i (vram_sel_o),
    .xr_sel_i   (xr_sel_o),
    .mem_wr_i   (mem_wr_o)
);

/* tests/blitter_tb.sv */
// Testbench for blitter_top.
// Memory models answer a read one cycle after its access:
// VRAM with address ^ A5A5, XR with address ^ 5A5A.
// Host commands are spaced 12 cycles apart, so none is ever replaced.
// Each memory access is checked against the expected list as it occurs.
`timescale 1ns/1ps

module blitter_tb;
    import xm_regs_pkg::*;
    import vram_pkg::*;

    localparam int GAP           = 12;
    localparam int BOOT_ACCESSES = CLEAR_WORDS + BANNER_LEN;
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_WAIT  = 2'd2;     // write while video holds memory
    localparam logic [15:0] VRAM_XOR = 16'hA5A5;
    localparam logic [15:0] XR_XOR   = 16'h5A5A;

    logic                  clk;
    logic                  reset_i;
    logic                  bus_wr_strobe_i;
    logic                  bus_rd_strobe_i;
    logic [XM_REG_W-1:0]   bus_reg_num_i;
    logic                  bus_bytesel_i;
    logic [XM_BYTE_W-1:0]  bus_data_i;
    logic [XM_BYTE_W-1:0]  bus_data_o;
    logic                  vgen_sel_i;
    logic                  vram_sel_o;
    logic                  xr_sel_o;
    logic                  mem_wr_o;
    logic [MEM_ADDR_W-1:0] mem_addr_o;
    logic [MEM_DATA_W-1:0] mem_data_o;
    logic [MEM_DATA_W-1:0] vram_data_i;
    logic [MEM_DATA_W-1:0] xr_data_i;
    logic                  reconfig_o;
    logic [1:0]            boot_select_o;
    logic [3:0]            intr_mask_o;

    // stimulus table of host byte accesses
    logic [1:0]            row_op[$];
    logic [XM_REG_W-1:0]   row_reg[$];
    logic                  row_sel[$];
    logic [XM_BYTE_W-1:0]  row_data[$];
    logic [XM_BYTE_W-1:0]  row_exp[$];
    int                    stall_pre[$];
    int                    stall_post[$];
    // expected memory accesses in order
    logic                  exp_xr[$];
    logic                  exp_wr[$];
    logic [MEM_ADDR_W-1:0] exp_addr[$];
    cell_t                 exp_data[$];

    int                    acc_count = 0;
    logic [31:0]           lfsr;
    int                    watchdog_cycles;
    logic                  table_ready = 1'b0;
    logic                  model_rd_vram;
    logic                  model_rd_xr;
    logic [MEM_ADDR_W-1:0] model_addr;

    blitter_top i_blitter_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [XM_BYTE_W-1:0] got, exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_cell(input string name, input cell_t got, input cell_t exp);
        if (got.word !== exp.word) begin
            stop_on_error($sformatf("** Error: %s = %h, expected %h", name, got.word, exp.word));
        end
    endtask

    task automatic check_addr(input string name, input logic [MEM_ADDR_W-1:0] got, exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_flags(input string name, input logic [2:0] got, exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[6:0], fb};
        end
        return r;
    endfunction

    task automatic add_row(input logic [1:0] op, input logic [XM_REG_W-1:0] rnum,
                           input logic sel, input logic [7:0] data, input logic [7:0] exp);
        row_op.push_back(op);
        row_reg.push_back(rnum);
        row_sel.push_back(sel);
        row_data.push_back(data);
        row_exp.push_back(exp);
    endtask

    task automatic add_write_pair(input logic [XM_REG_W-1:0] rnum, input logic [15:0] word);
        add_row(OP_WRITE, rnum, 1'b0, word[15:8], 8'h00);
        add_row(OP_WRITE, rnum, 1'b1, word[7:0], 8'h00);
    endtask

    task automatic add_read_pair(input logic [XM_REG_W-1:0] rnum, input logic [15:0] word);
        add_row(OP_READ, rnum, 1'b0, 8'h00, word[15:8]);
        add_row(OP_READ, rnum, 1'b1, 8'h00, word[7:0]);
    endtask

    task automatic add_access(input logic xr, input logic wr,
                              input logic [MEM_ADDR_W-1:0] addr, input cell_t data);
        exp_xr.push_back(xr);
        exp_wr.push_back(wr);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic build_table();
        cell_t      c;
        cell_t      w0;
        cell_t      w1;
        cell_t      wx;
        cell_t      ws;
        string      hex_chars;
        string      banner_str;
        logic [7:0] ver_glyph[4];
        hex_chars    = "0123456789abcdef";
        banner_str   = $sformatf("%s", BANNER);
        ver_glyph[0] = hex_chars[VERSION[11:8]];
        ver_glyph[1] = ".";
        ver_glyph[2] = hex_chars[VERSION[7:4]];
        ver_glyph[3] = hex_chars[VERSION[3:0]];
        for (int k = 0; k < CLEAR_WORDS; k++) begin
            add_access(1'b0, 1'b1, MEM_ADDR_W'(k), CLEAR_CELL);
        end
        for (int k = 0; k < BANNER_LEN; k++) begin
            c.ch.attr  = BANNER_ATTR;
            c.ch.glyph = (k < 8) ? banner_str[k] : ver_glyph[k - 8];
            add_access(1'b0, 1'b1, MEM_ADDR_W'(TILES_WIDE + 1 + k), c);
        end
        w0.word[15:8] = rand_bits(8);
        w0.word[7:0]  = rand_bits(8);
        w1.word[15:8] = rand_bits(8);
        w1.word[7:0]  = rand_bits(8);
        wx.word[15:8] = rand_bits(8);
        wx.word[7:0]  = rand_bits(8);
        ws.word[15:8] = rand_bits(8);
        ws.word[7:0]  = rand_bits(8);

        add_write_pair(XM_WR_INCR, 16'h0003);       // VRAM writes
        add_write_pair(XM_WR_ADDR, 16'h0100);
        add_write_pair(XM_DATA, w0.word);
        add_access(1'b0, 1'b1, 16'h0100, w0);
        add_write_pair(XM_DATA_2, w1.word);
        add_access(1'b0, 1'b1, 16'h0103, w1);
        add_read_pair(XM_WR_ADDR, 16'h0106);

        add_write_pair(XM_RD_INCR, 16'h0002);       // VRAM read and prefetch
        add_write_pair(XM_RD_ADDR, 16'h0200);
        add_access(1'b0, 1'b0, 16'h0200, '0);
        add_read_pair(XM_DATA, 16'h0200 ^ VRAM_XOR);
        add_access(1'b0, 1'b0, 16'h0202, '0);
        add_read_pair(XM_DATA, 16'h0202 ^ VRAM_XOR);
        add_access(1'b0, 1'b0, 16'h0204, '0);

        add_write_pair(XM_XR_ADDR, 16'h0010);       // XR read then write
        add_access(1'b1, 1'b0, 16'h0010, '0);
        add_read_pair(XM_XR_DATA, 16'h0010 ^ XR_XOR);
        add_write_pair(XM_XR_DATA, wx.word);
        add_access(1'b1, 1'b1, 16'h0010, wx);
        add_read_pair(XM_XR_ADDR, 16'h0011);

        add_row(OP_WRITE, XM_DATA, 1'b0, ws.word[15:8], 8'h00);
        add_row(OP_WAIT, XM_DATA, 1'b1, ws.word[7:0], 8'h00);
        stall_pre.push_back(1 + int'(rand_bits(3)));
        stall_post.push_back(2 + int'(rand_bits(3)));
        add_access(1'b0, 1'b1, 16'h0106, ws);
        add_read_pair(XM_WR_ADDR, 16'h0109);

        add_write_pair(XM_SYS_CTRL, 16'h5F00);
        add_read_pair(XM_SYS_CTRL, 16'h0F00);       // idle with mask F
        add_row(OP_WRITE, XM_RD_INCR, 1'b0, 8'h0C, 8'h00);
        add_row(OP_WRITE, XM_WR_INCR, 1'b1, 8'h07, 8'h00);
        add_read_pair(XM_WR_INCR, 16'h0007);        // latch tag mismatch gives 00
    endtask

    task automatic drive_slot();
        @(posedge clk);
        #5;
    endtask

    task automatic host_write(input logic [XM_REG_W-1:0] rnum, input logic sel,
                              input logic [7:0] data);
        drive_slot();
        bus_wr_strobe_i = 1'b1;
        bus_reg_num_i   = rnum;
        bus_bytesel_i   = sel;
        bus_data_i      = data;
        drive_slot();
        bus_wr_strobe_i = 1'b0;
    endtask

    task automatic host_read(input logic [XM_REG_W-1:0] rnum, input logic sel,
                             input logic [7:0] exp);
        drive_slot();
        bus_rd_strobe_i = 1'b1;
        bus_reg_num_i   = rnum;
        bus_bytesel_i   = sel;
        @(negedge clk);
        check_byte("bus_data_o", bus_data_o, exp);
        drive_slot();
        bus_rd_strobe_i = 1'b0;
    endtask

    // memory models drive read data in the cycle after the access
    initial begin
        vram_data_i = '0;
        xr_data_i   = '0;
        forever begin
            @(negedge clk);
            model_rd_vram = vram_sel_o && !mem_wr_o;
            model_rd_xr   = xr_sel_o && !mem_wr_o;
            model_addr    = mem_addr_o;
            drive_slot();
            if (model_rd_vram) begin
                vram_data_i = model_addr ^ VRAM_XOR;
            end
            if (model_rd_xr) begin
                xr_data_i = model_addr ^ XR_XOR;
            end
        end
    end

    // bus monitor
    always @(negedge clk) begin
        if (vram_sel_o || xr_sel_o) begin
            if (acc_count >= exp_addr.size()) begin
                stop_on_error($sformatf("unexpected memory access at address %h", mem_addr_o));
            end else begin
                check_flags("{vram_sel_o, xr_sel_o, mem_wr_o}",
                            {vram_sel_o, xr_sel_o, mem_wr_o},
                            {!exp_xr[acc_count], exp_xr[acc_count], exp_wr[acc_count]});
                check_addr("mem_addr_o", mem_addr_o, exp_addr[acc_count]);
                if (exp_wr[acc_count]) begin
                    check_cell("mem_data_o", cell_t'(mem_data_o), exp_data[acc_count]);
                end
                acc_count++;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (watchdog_cycles) @(posedge clk);
        stop_on_error($sformatf("watchdog fired after %0d cycles, the run hung", watchdog_cycles));
    end

    initial begin
        int stall_total;
        int wait_idx;
        int seen;
        reset_i         = 1'b1;
        bus_wr_strobe_i = 1'b0;
        bus_rd_strobe_i = 1'b0;
        bus_reg_num_i   = '0;
        bus_bytesel_i   = 1'b0;
        bus_data_i      = '0;
        vgen_sel_i      = 1'b0;
        lfsr            = 32'h11c0_31ad;
        build_table();
        stall_total = 0;
        foreach (stall_pre[i]) begin
            stall_total += stall_pre[i] + stall_post[i];
        end
        watchdog_cycles = (row_op.size() * GAP + BOOT_ACCESSES + stall_total) * 2;
        table_ready     = 1'b1;

        repeat (4) drive_slot();
        reset_i       = 1'b0;
        bus_reg_num_i = XM_SYS_CTRL;
        @(negedge clk);
        check_byte("bus_data_o", bus_data_o, 8'h88);    // busy and mask 1000
        check_byte("{reconfig_o, boot_select_o, intr_mask_o}",
                   {1'b0, reconfig_o, boot_select_o, intr_mask_o}, 8'h08);
        wait (acc_count == BOOT_ACCESSES);
        drive_slot();
        @(negedge clk);
        check_byte("bus_data_o", bus_data_o, 8'h08);
        drive_slot();

        wait_idx = 0;
        foreach (row_op[i]) begin
            case (row_op[i])
                OP_READ: host_read(row_reg[i], row_sel[i], row_exp[i]);
                OP_WAIT: begin
                    vgen_sel_i = 1'b1;
                    seen       = acc_count;
                    repeat (stall_pre[wait_idx]) drive_slot();
                    host_write(row_reg[i], row_sel[i], row_data[i]);
                    repeat (stall_post[wait_idx]) drive_slot();
                    if (acc_count != seen) begin
                        stop_on_error("memory was accessed while the video generator held it");
                    end
                    vgen_sel_i = 1'b0;
                    wait_idx++;
                end
                default: host_write(row_reg[i], row_sel[i], row_data[i]);
            endcase
            repeat (GAP) drive_slot();
        end

        @(negedge clk);
        check_byte("{reconfig_o, boot_select_o, intr_mask_o}",
                   {1'b0, reconfig_o, boot_select_o, intr_mask_o}, 8'h5F);
        if (acc_count != exp_addr.size()) begin
            stop_on_error($sformatf("only %0d of %0d memory accesses happened",
                                    acc_count, exp_addr.size()));
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* blitter_top.f */
source/xm_regs_pkg.sv
source/vram_pkg.sv
source/blit_regs.sv
source/boot_writer.sv
source/mem_arbiter.sv
source/blitter_top.sv
tests/blitter_chk.sv
tests/blitter_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the blitter_top testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module blitter_tb -f blitter_top.f -o blitter_sim
./obj_dir/blitter_sim > sim.log 2>&1 || true
cat sim.log
if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
